//--- rx_scanner.f
hw/rx_scan_pkg.sv
hw/scan_bus_if.sv
hw/frame_sync.sv
hw/ones_chksum.sv
hw/crc32_check.sv
hw/ip_hdr_check.sv
hw/l4_patt.sv
hw/udp_port_cam.sv
hw/rx_scanner.sv
dv/rx_scanner_asserts.sv
dv/rx_scanner_tb.sv

//--- Bender.yml
package:
  name: rx_scanner

sources:
  - hw/rx_scan_pkg.sv
  - hw/scan_bus_if.sv
  - hw/frame_sync.sv
  - hw/ones_chksum.sv
  - hw/crc32_check.sv
  - hw/ip_hdr_check.sv
  - hw/l4_patt.sv
  - hw/udp_port_cam.sv
  - hw/rx_scanner.sv
  - target: simulation
    files:
      - dv/rx_scanner_asserts.sv
      - dv/rx_scanner_tb.sv

//--- dv/rx_scanner_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rx_scanner_tb;
	import rx_scan_pkg::*;

	// Worst frame is gap, preamble, SFD and 300 octets
	localparam int frame_cycles = 12 + 8 + 300 + 8;
	localparam int n_frames = 16;
	localparam int cycle_limit = n_frames * frame_cycles + 500;

	logic clk;
	logic rst_n;
	octet_t eth_in;
	logic eth_in_s;
	logic eth_in_e;
	logic enable_rx;
	logic [3:0] ip_a;
	octet_t ip_d;
	logic [3:0] pno_a;
	octet_t pno_d;
	logic busy;
	logic keep;
	octet_t odata;
	logic odata_s;
	logic odata_f;
	logic status_valid;
	logic [7:0] status_vec;
	oct_cnt_t pack_len;

	octet_t cfg_mem [16];
	octet_t port_mem [16];
	octet_t body [2048];
	int seed;
	int cycles;
	int n;
	logic [7:0] exp_status_q [$];
	int exp_len_q [$];
	string exp_name_q [$];
	octet_t exp_byte_q [$];
	int hint_step;
	logic keep_exp;
	string hint_name;

	rx_scanner u_rx_scanner (
		.clk(clk),
		.rst_n(rst_n),
		.eth_in(eth_in),
		.eth_in_s(eth_in_s),
		.eth_in_e(eth_in_e),
		.enable_rx(enable_rx),
		.ip_a(ip_a),
		.ip_d(ip_d),
		.pno_a(pno_a),
		.pno_d(pno_d),
		.busy(busy),
		.keep(keep),
		.odata(odata),
		.odata_s(odata_s),
		.odata_f(odata_f),
		.status_valid(status_valid),
		.status_vec(status_vec),
		.pack_len(pack_len)
	);

	bind rx_scanner rx_scanner_asserts u_asserts (
		.clk(clk),
		.rst_n(rst_n),
		.odata_s(odata_s),
		.odata_f(odata_f),
		.status_valid(status_valid),
		.busy(busy),
		.keep(keep)
	);

	// Single-cycle config and port memories
	always @(posedge clk) begin
		ip_d <= cfg_mem[ip_a];
		pno_d <= port_mem[pno_a];
	end

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_stop(string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "Run stopped");
	endtask

	function automatic logic [15:0] table_port(int i);
		return 16'h1f40 + 16'(i * 7);
	endfunction

	// One's-complement sum over body octets with an odd tail padded by zero
	function automatic logic [15:0] ones_sum(int start, int len);
		logic [16:0] s;
		logic [15:0] w;
		s = '0;
		for (int i = 0; i < len; i += 2) begin
			w = {body[start + i], (i + 1 < len) ? body[start + i + 1] : 8'h00};
			s = {1'b0, s[15:0]} + w;
			s = s[15:0] + 16'(s[16]);
		end
		return s[15:0];
	endfunction

	// Ethernet FCS value as the inverted reflected CRC-32
	function automatic logic [31:0] crc32_of(int len);
		logic [31:0] c;
		octet_t d;
		c = 32'hffffffff;
		for (int k = 0; k < len; k++) begin
			d = body[k];
			for (int i = 0; i < 8; i++) begin
				if (c[0] ^ d[i]) c = (c >> 1) ^ 32'hedb88320;
				else c = c >> 1;
			end
		end
		return ~c;
	endfunction

	task automatic put16(int a, logic [15:0] v);
		body[a] = v[15:8];
		body[a + 1] = v[7:0];
	endtask

	task automatic eth_hdr(bit mac_ok, logic [15:0] etype);
		for (int i = 0; i < 6; i++) body[i] = cfg_mem[i];
		if (!mac_ok) body[5] = body[5] ^ 8'h01;
		// Unicast source 02:00:00:00:00:01
		for (int i = 6; i < 12; i++) body[i] = 8'h00;
		body[6] = 8'h02;
		body[11] = 8'h01;
		put16(12, etype);
	endtask

	task automatic ip_hdr(int ip_len, octet_t proto);
		body[14] = 8'h45;
		body[15] = 8'h00;
		put16(16, 16'(ip_len));
		put16(18, 16'h1234);
		// DF set and no fragment offset
		put16(20, 16'h4000);
		body[22] = 8'd64;
		body[23] = proto;
		put16(24, 16'h0000);
		put16(26, 16'hc0a8);
		put16(28, 16'h0105);
		for (int i = 0; i < 4; i++) body[30 + i] = cfg_mem[6 + i];
		put16(24, ~ones_sum(14, 20));
	endtask

	// len counts the whole frame including the FCS
	task automatic build_udp(bit mac_ok, logic [15:0] port, int len);
		int pay;
		pay = len - 4 - 42;
		for (int i = 42; i < len - 4; i++) body[i] = octet_t'($random(seed));
		eth_hdr(mac_ok, 16'h0800);
		ip_hdr(28 + pay, 8'h11);
		put16(34, 16'hc350);
		put16(36, port);
		put16(38, 16'(8 + pay));
		put16(40, 16'h0000);
	endtask

	task automatic build_icmp(bit corrupt, int len);
		int ip_len;
		ip_len = len - 4 - 14;
		for (int i = 42; i < len - 4; i++) body[i] = octet_t'($random(seed));
		eth_hdr(1'b1, 16'h0800);
		ip_hdr(ip_len, 8'h01);
		// Echo request with id and sequence
		body[34] = 8'h08;
		body[35] = 8'h00;
		put16(36, 16'h0000);
		put16(38, 16'h0042);
		put16(40, 16'h0001);
		put16(36, ~ones_sum(34, ip_len - 20));
		if (corrupt) body[45] = body[45] ^ 8'h40;
	endtask

	task automatic build_arp(bit tpa_ok);
		for (int i = 0; i < 60; i++) body[i] = 8'h00;
		eth_hdr(1'b1, 16'h0806);
		for (int i = 0; i < 6; i++) body[i] = 8'hff;
		put16(14, 16'h0001);
		put16(16, 16'h0800);
		body[18] = 8'h06;
		body[19] = 8'h04;
		put16(20, 16'h0001);
		body[22] = 8'h02;
		put16(28, 16'hc0a8);
		put16(30, 16'h0105);
		for (int i = 0; i < 4; i++) body[38 + i] = cfg_mem[6 + i];
		if (!tpa_ok) body[41] = body[41] ^ 8'h10;
	endtask

	task automatic add_crc(int len);
		logic [31:0] c;
		c = crc32_of(len - 4);
		// FCS goes out low octet first
		for (int i = 0; i < 4; i++) body[len - 4 + i] = c[8 * i +: 8];
	endtask

	// Status byte from the protocol rules
	function automatic logic [7:0] expected_status(int len);
		logic crc_ok;
		logic mac_ok;
		logic uni;
		logic ip_ok;
		logic arp_ok;
		logic icmp_ok;
		logic udp_ok;
		logic hit;
		logic [2:0] idx;
		logic [1:0] cat;
		int ip_len;
		logic [15:0] dport;
		crc_ok = {body[len - 1], body[len - 2], body[len - 3], body[len - 4]} == crc32_of(len - 4);
		mac_ok = 1'b1;
		for (int i = 0; i < 6; i++) if (body[i] != cfg_mem[i]) mac_ok = 1'b0;
		uni = !body[6][0];
		ip_len = {body[16], body[17]};
		ip_ok = uni && crc_ok && mac_ok && body[12] == 8'h08 && body[13] == 8'h00 &&
			body[14] == 8'h45 && (body[20] & 8'hbf) == 8'h00 && body[21] == 8'h00 &&
			body[22] != 8'h00 && ones_sum(14, 20) == 16'hffff && len >= ip_len + 18;
		for (int i = 0; i < 4; i++) if (body[30 + i] != cfg_mem[6 + i]) ip_ok = 1'b0;
		arp_ok = uni && crc_ok && {body[12], body[13]} == 16'h0806 &&
			{body[14], body[15]} == 16'h0001 && {body[16], body[17]} == 16'h0800 &&
			body[18] == 8'h06 && body[19] == 8'h04 && {body[20], body[21]} == 16'h0001;
		for (int i = 0; i < 4; i++) if (body[38 + i] != cfg_mem[6 + i]) arp_ok = 1'b0;
		icmp_ok = ip_ok && body[23] == 8'h01 && body[34] == 8'h08 && body[35] == 8'h00 &&
			ones_sum(34, ip_len - 20) == 16'hffff;
		// Lowest matching table entry wins
		dport = {body[36], body[37]};
		hit = 1'b0;
		idx = '0;
		for (int i = 7; i >= 0; i--) begin
			if (table_port(i) == dport) begin
				hit = 1'b1;
				idx = 3'(i);
			end
		end
		udp_ok = ip_ok && body[23] == 8'h11 && {body[34], body[35]} >= 16'd1024 &&
			dport != 16'h0000 && int'({body[38], body[39]}) + 20 <= ip_len && hit;
		if (udp_ok) cat = cat_udp;
		else if (icmp_ok) cat = cat_icmp;
		else if (arp_ok) cat = cat_arp;
		else cat = cat_other;
		return {udp_ok ? idx : 3'd0, ip_ok, mac_ok, crc_ok, cat};
	endfunction

	task automatic drive_frame(int len, int pre_len, int gap, bit en);
		for (int i = 0; i < gap; i++) begin
			@(posedge clk);
			#1;
			eth_in_s = 1'b0;
			eth_in = 8'h00;
			enable_rx = en;
		end
		for (int i = 0; i < pre_len + 1 + len; i++) begin
			@(posedge clk);
			#1;
			eth_in_s = 1'b1;
			if (i < pre_len) eth_in = 8'h55;
			else if (i == pre_len) eth_in = 8'hd5;
			else eth_in = body[i - pre_len - 1];
		end
		@(posedge clk);
		#1;
		eth_in_s = 1'b0;
		eth_in = 8'h00;
		enable_rx = 1'b1;
	endtask

	task automatic send_checked(string name, int len, logic [1:0] want_cat);
		logic [7:0] st;
		st = expected_status(len);
		assert (st[1:0] == want_cat)
			else fail_stop($sformatf("Frame %s was not built as category %0d", name, want_cat));
		exp_status_q.push_back(st);
		exp_len_q.push_back(len);
		exp_name_q.push_back(name);
		for (int i = 0; i < len; i++) exp_byte_q.push_back(body[i]);
		drive_frame(len, 7, 12, 1'b1);
	endtask

	// Compares output octets, the frame status and the busy and keep hints after it
	always @(posedge clk) begin : compare
		octet_t eb;
		logic [7:0] es;
		int el;
		string nm;
		if (rst_n) begin
			nm = (exp_name_q.size() > 0) ? exp_name_q[0] : "none";
			// Keep follows the status by one cycle and busy drops one cycle after that
			if (hint_step == 1) begin
				assert (keep == keep_exp)
					else fail_stop($sformatf("ERR %s keep expected %0b actual %0b",
						hint_name, keep_exp, keep));
				if (keep_exp) begin
					assert (busy)
						else fail_stop($sformatf("ERR %s busy expected 1 actual %0b",
							hint_name, busy));
				end
				hint_step = 2;
			end else if (hint_step == 2) begin
				assert (!busy)
					else fail_stop($sformatf("ERR %s busy expected 0 actual %0b",
						hint_name, busy));
				assert (!keep)
					else fail_stop($sformatf("ERR %s keep expected 0 actual %0b",
						hint_name, keep));
				hint_step = 0;
			end
			if (odata_s) begin
				assert (exp_byte_q.size() > 0)
					else fail_stop("Output octet seen while no frame was expected");
				eb = exp_byte_q.pop_front();
				assert (odata == eb)
					else fail_stop($sformatf("ERR %s odata expected %h actual %h", nm, eb, odata));
			end
			if (status_valid) begin
				assert (exp_status_q.size() > 0)
					else fail_stop("Status seen while no frame was expected");
				es = exp_status_q.pop_front();
				el = exp_len_q.pop_front();
				void'(exp_name_q.pop_front());
				assert (status_vec == es)
					else fail_stop($sformatf("ERR %s status_vec expected %h actual %h",
						nm, es, status_vec));
				assert (pack_len == oct_cnt_t'(el))
					else fail_stop($sformatf("ERR %s pack_len expected %0d actual %0d",
						nm, el, pack_len));
				keep_exp = es[1:0] != cat_other;
				hint_name = nm;
				hint_step = 1;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) fail_stop("Timeout, the DUT stopped producing frame results");
	end

	initial begin
		seed = 54;
		cycles = 0;
		hint_step = 0;
		rst_n = 1'b0;
		eth_in = 8'h00;
		eth_in_s = 1'b0;
		eth_in_e = 1'b0;
		enable_rx = 1'b1;
		ip_d = 8'h00;
		pno_d = 8'h00;
		// MAC and IP followed by a filler tied to the address
		cfg_mem = '{8'h02, 8'h12, 8'h34, 8'h56, 8'h78, 8'h9a, 8'hc0, 8'ha8, 8'h01, 8'h2a,
			8'hca, 8'hcb, 8'hcc, 8'hcd, 8'hce, 8'hcf};
		for (int i = 0; i < pno_entries; i++) begin
			port_mem[2 * i] = octet_t'(table_port(i) >> 8);
			port_mem[2 * i + 1] = octet_t'(table_port(i));
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		build_udp(1'b1, table_port(5), 80);
		add_crc(80);
		send_checked("udp_entry5", 80, cat_udp);

		build_arp(1'b1);
		add_crc(64);
		send_checked("arp_our_ip", 64, cat_arp);
		build_arp(1'b0);
		add_crc(64);
		send_checked("arp_other_ip", 64, cat_other);

		build_icmp(1'b0, 100);
		add_crc(100);
		send_checked("icmp_echo", 100, cat_icmp);
		build_icmp(1'b1, 100);
		add_crc(100);
		send_checked("icmp_bad_sum", 100, cat_other);

		build_udp(1'b1, table_port(3), 72);
		add_crc(72);
		body[70] = body[70] ^ 8'h04;
		send_checked("crc_bit_flip", 72, cat_other);
		build_udp(1'b0, table_port(3), 72);
		add_crc(72);
		send_checked("wrong_dst_mac", 72, cat_other);

		// Receiver disabled and then a gap too short with a two-octet preamble
		build_udp(1'b1, table_port(2), 70);
		add_crc(70);
		drive_frame(70, 7, 12, 1'b0);
		drive_frame(70, 2, 5, 1'b1);
		repeat (4) @(posedge clk);
		send_checked("after_drops", 70, cat_udp);

		// Odd frames use a port missing from the table
		for (int k = 0; k < 6; k++) begin
			n = 64 + int'($unsigned($random(seed)) % 237);
			build_udp(1'b1, (k % 2 == 0) ? table_port(k) : 16'h0400 + 16'(k), n);
			add_crc(n);
			send_checked($sformatf("random_len_%0d", k), n, (k % 2 == 0) ? cat_udp : cat_other);
		end

		while (exp_status_q.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk);
		if (exp_byte_q.size() == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			fail_stop("Output octets missing at the end of the run");
		end
	end

endmodule

`default_nettype wire

//--- dv/rx_scanner_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rx_scanner_asserts (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic odata_s,
	input wire logic odata_f,
	input wire logic status_valid,
	input wire logic busy,
	input wire logic keep
);

	// Frame end marks a real output octet
	assert property (@(posedge clk) disable iff (!rst_n) odata_f |-> odata_s)
		else $error("odata_f high without odata_s");

	// Status comes with the last octet of each frame
	assert property (@(posedge clk) disable iff (!rst_n) $fell(odata_s) |-> $past(status_valid))
		else $error("odata_s ended without status_valid on its last octet");

	// Hints start low out of reset
	assert property (@(posedge clk) $rose(rst_n) |-> (!keep && !busy))
		else $error("busy or keep high right after reset");

endmodule

`default_nettype wire

//--- hw/rx_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module rx_scanner #(
	parameter bit handle_arp = 1'b1,
	parameter bit handle_icmp = 1'b1
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire rx_scan_pkg::octet_t eth_in,
	input wire logic eth_in_s,
	// Error flag from the PHY is not acted on
	input wire logic eth_in_e,
	input wire logic enable_rx,
	output logic [3:0] ip_a,
	input wire rx_scan_pkg::octet_t ip_d,
	output logic [3:0] pno_a,
	input wire rx_scan_pkg::octet_t pno_d,
	output logic busy,
	output logic keep,
	output rx_scan_pkg::octet_t odata,
	output logic odata_s,
	output logic odata_f,
	output logic status_valid,
	output logic [7:0] status_vec,
	output rx_scan_pkg::oct_cnt_t pack_len
);
	import rx_scan_pkg::*;

	scan_bus_if bus ();

	logic crc_ok;
	logic pass_ip0;
	logic pass_arp0;
	logic pass_icmp0;
	logic pass_udp0;
	logic port_hit;
	port_idx_t port_idx;
	len16_t ip_length;
	logic ip_m;
	logic want_eth;
	logic want_arp;
	logic want_ip;
	logic pass_ethmac;
	logic pass_arpip;
	logic pass_ipdst;
	logic unicast_src;
	logic ip_len_ok;
	logic pass_arp;
	logic pass_ip;
	logic pass_icmp;
	logic pass_udp;
	category_t category;
	port_idx_t port_p;

	frame_sync u_frame_sync (
		.clk(clk),
		.rst_n(rst_n),
		.eth_in(eth_in),
		.eth_in_s(eth_in_s),
		.enable_rx(enable_rx),
		.bus(bus),
		.odata(odata),
		.odata_s(odata_s),
		.odata_f(odata_f),
		.pack_len(pack_len)
	);

	crc32_check u_crc (.clk(clk), .rst_n(rst_n), .bus(bus), .crc_ok(crc_ok));

	ip_hdr_check u_ip_hdr (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus),
		.pass(pass_ip0),
		.ip_length(ip_length)
	);

	l4_patt #(.handle_arp(handle_arp), .handle_icmp(handle_icmp)) u_l4 (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus),
		.ip_length(ip_length),
		.pass_arp(pass_arp0),
		.pass_icmp(pass_icmp0),
		.pass_udp(pass_udp0)
	);

	udp_port_cam u_cam (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus),
		.pno_a(pno_a),
		.pno_d(pno_d),
		.port_hit(port_hit),
		.port_idx(port_idx)
	);

	// Config address one cycle ahead of the octet it is compared with
	always_comb begin
		if (bus.cnt >= off_arp_tpa) ip_a = 4'(bus.cnt - off_arp_tpa + ip_base);
		else if (bus.cnt >= off_ip_dst) ip_a = 4'(bus.cnt - off_ip_dst + ip_base);
		else ip_a = 4'(bus.cnt + mac_base);
	end
	assign ip_m = ip_d == bus.data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			want_eth <= 1'b0;
			want_arp <= 1'b0;
			want_ip <= 1'b0;
			pass_ethmac <= 1'b0;
			pass_arpip <= 1'b0;
			pass_ipdst <= 1'b0;
			unicast_src <= 1'b0;
			ip_len_ok <= 1'b0;
		end else begin
			want_eth <= bus.cnt < 6;
			want_arp <= bus.cnt >= off_arp_tpa && bus.cnt < off_arp_tpa + 4;
			want_ip <= bus.cnt >= off_ip_dst && bus.cnt < off_ip_dst + 4;
			if (want_eth && !ip_m) pass_ethmac <= 1'b0;
			if (want_arp && !ip_m) pass_arpip <= 1'b0;
			if (want_ip && !ip_m) pass_ipdst <= 1'b0;
			// Group bit of the first source MAC octet
			if (bus.cnt == off_src_mac + 1) unicast_src <= ~bus.data[0];
			// Frame must hold the IP datagram plus header and FCS
			ip_len_ok <= {6'd0, bus.cnt} >= {1'b0, ip_length} + 17'd18;
			if (bus.cnt == 0) begin
				pass_ethmac <= 1'b1;
				pass_arpip <= 1'b1;
				pass_ipdst <= 1'b1;
			end
			// Optimistic until the source MAC is seen, keeps busy up early
			if (bus.cnt == 1) unicast_src <= 1'b1;
		end
	end

	assign pass_arp = unicast_src & crc_ok & pass_arp0 & pass_arpip;
	assign pass_ip = unicast_src & crc_ok & pass_ethmac & pass_ip0 & pass_ipdst & ip_len_ok;
	assign pass_icmp = pass_ip & pass_icmp0;
	assign pass_udp = pass_ip & pass_udp0 & port_hit;

	always_comb begin
		if (pass_udp) category = cat_udp;
		else if (pass_icmp) category = cat_icmp;
		else if (pass_arp) category = cat_arp;
		else category = cat_other;
	end

	// Port index only means something for a UDP hit
	assign port_p = pass_udp ? port_idx : '0;
	assign status_vec = {port_p, pass_ip, pass_ethmac, crc_ok, category};
	assign status_valid = odata_f;

	// Busy follows the template matches, keep waits for the full verdict
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			keep <= 1'b0;
		end else begin
			busy <= odata_s & ((unicast_src & pass_arp0) |
				(unicast_src & pass_ethmac & pass_ip0 & (pass_udp0 | pass_icmp0)));
			keep <= odata_s & (category != cat_other);
		end
	end

endmodule

`default_nettype wire

//--- hw/udp_port_cam.sv
`timescale 1ns/1ps
`default_nettype none

module udp_port_cam (
	input wire logic clk,
	input wire logic rst_n,
	scan_bus_if.chk bus,
	output logic [3:0] pno_a,
	input wire rx_scan_pkg::octet_t pno_d,
	output logic port_hit,
	output rx_scan_pkg::port_idx_t port_idx
);
	import rx_scan_pkg::*;

	len16_t port;
	octet_t data_d;
	octet_t hi_d;
	logic [3:0] addr_d;
	logic run;
	logic rd_v;

	always_ff @(posedge clk) begin
		data_d <= bus.data;
		// Destination port complete when octet 37 is on the bus
		if (bus.cnt == off_udp_dport + 2) port <= {data_d, bus.data};
		// Address of the entry now on pno_d
		addr_d <= pno_a;
		if (rd_v && !addr_d[0]) hi_d <= pno_d;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			rd_v <= 1'b0;
			pno_a <= '0;
			port_hit <= 1'b0;
			port_idx <= '0;
		end else begin
			rd_v <= run;
			if (run) begin
				pno_a <= pno_a + 1'b1;
				if (pno_a == 4'(2 * pno_entries - 1)) run <= 1'b0;
			end
			// Scan starts together with the last port octet
			if (bus.cnt == off_udp_dport + 1) begin
				run <= 1'b1;
				pno_a <= '0;
			end
			// Low octet read completes an entry, first match wins
			if (rd_v && addr_d[0] && !port_hit && {hi_d, pno_d} == port) begin
				port_hit <= 1'b1;
				port_idx <= port_idx_t'(addr_d[3:1]);
			end
			if (bus.cnt == 0) begin
				port_hit <= 1'b0;
				port_idx <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/l4_patt.sv
`timescale 1ns/1ps
`default_nettype none

module l4_patt #(
	parameter bit handle_arp = 1'b1,
	parameter bit handle_icmp = 1'b1
) (
	input wire logic clk,
	input wire logic rst_n,
	scan_bus_if.chk bus,
	input wire rx_scan_pkg::len16_t ip_length,
	output logic pass_arp,
	output logic pass_icmp,
	output logic pass_udp
);
	import rx_scan_pkg::*;

	octet_t arp_tmpl;
	octet_t data_d;
	logic arp_want;
	logic arp_r;
	logic icmp_r;
	logic icmp_fail;
	logic udp_r;
	len16_t udp_len;
	len16_t cnt16;
	len16_t ip_end;
	logic icmp_gate;
	logic icmp_sum_ok;

	assign cnt16 = len16_t'(bus.cnt);
	// Count at which the last IP octet sits on the bus
	assign ip_end = ip_length + len16_t'(off_ip_hdr);
	assign icmp_gate = cnt16 > off_l4 && cnt16 <= ip_end;

	// ARP request for IPv4 over Ethernet
	always_ff @(posedge clk) begin
		case (bus.cnt)
			off_ethertype: arp_tmpl <= 8'h08;
			off_ethertype + 1: arp_tmpl <= 8'h06;
			off_ethertype + 3: arp_tmpl <= 8'h01;
			off_ethertype + 4: arp_tmpl <= 8'h08;
			off_ethertype + 6: arp_tmpl <= 8'h06;
			off_ethertype + 7: arp_tmpl <= 8'h04;
			off_ethertype + 9: arp_tmpl <= 8'h01;
			default: arp_tmpl <= 8'h00;
		endcase
		data_d <= bus.data;
		if (bus.cnt == off_udp_len + 2) udp_len <= {data_d, bus.data};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arp_want <= 1'b0;
			arp_r <= 1'b0;
			icmp_r <= 1'b0;
			icmp_fail <= 1'b0;
			udp_r <= 1'b0;
		end else begin
			arp_want <= bus.cnt >= off_ethertype && bus.cnt < off_ethertype + 10;
			if (arp_want && bus.data != arp_tmpl) arp_r <= 1'b0;
			// Octet k is on the bus while cnt is k+1
			if (bus.cnt == off_ip_proto + 1) begin
				if (bus.data != 8'h01) icmp_r <= 1'b0;
				if (bus.data != 8'h11) udp_r <= 1'b0;
			end
			// Echo request type, code zero
			if (bus.cnt == off_l4 + 1 && bus.data != 8'h08) icmp_r <= 1'b0;
			if (bus.cnt == off_l4 + 2 && bus.data != 8'h00) icmp_r <= 1'b0;
			// Source ports below 1024 are refused
			if (bus.cnt == off_l4 + 1 && bus.data[7:2] == 6'd0) udp_r <= 1'b0;
			// Destination port zero
			if (bus.cnt == off_udp_dport + 2 && {data_d, bus.data} == 16'h0000) udp_r <= 1'b0;
			// UDP length must fit inside the IP payload
			if (bus.cnt == off_udp_len + 3 &&
				{1'b0, udp_len} + 17'(ip_hdr_len) > {1'b0, ip_length}) udp_r <= 1'b0;
			// ICMP sum checked once the IP payload has passed
			if (cnt16 > off_l4 && cnt16 == ip_end + 1) icmp_fail <= ~icmp_sum_ok;
			if (bus.cnt == 0) begin
				arp_r <= 1'b1;
				icmp_r <= 1'b1;
				icmp_fail <= 1'b0;
				udp_r <= 1'b1;
			end
		end
	end

	ones_chksum u_icmp_sum (
		.clk(clk),
		.rst_n(rst_n),
		.clear(bus.cnt == 0),
		.gate(icmp_gate),
		.din(bus.data),
		.all_ones(icmp_sum_ok)
	);

	assign pass_arp = handle_arp & arp_r;
	assign pass_icmp = handle_icmp & icmp_r & ~icmp_fail;
	assign pass_udp = udp_r;

endmodule

`default_nettype wire

//--- hw/ip_hdr_check.sv
`timescale 1ns/1ps
`default_nettype none

module ip_hdr_check (
	input wire logic clk,
	input wire logic rst_n,
	scan_bus_if.chk bus,
	output logic pass,
	output rx_scan_pkg::len16_t ip_length
);
	import rx_scan_pkg::*;

	octet_t tmpl;
	octet_t data_d;
	octet_t df_mask;
	logic want;
	logic mask_df;
	logic ttl_flag;
	logic pass_r;
	logic sum_clear;
	logic sum_gate;
	logic sum_ok;
	logic sum_fail;

	// Template lines up with the octet one cycle later
	always_ff @(posedge clk) begin
		case (bus.cnt)
			off_ethertype: tmpl <= 8'h08;
			off_ethertype + 1: tmpl <= 8'h00;
			// Version 4, IHL 5 only
			off_ip_hdr: tmpl <= 8'h45;
			default: tmpl <= 8'h00;
		endcase
		data_d <= bus.data;
		// Total length octets 16 and 17
		if (bus.cnt == off_ip_len + 2) ip_length <= {data_d, bus.data};
	end

	// DF bit is ignored, all other flag and offset bits must be zero
	assign df_mask = {1'b1, ~mask_df, 6'h3f};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			want <= 1'b0;
			mask_df <= 1'b0;
			ttl_flag <= 1'b0;
			pass_r <= 1'b0;
			sum_clear <= 1'b0;
			sum_gate <= 1'b0;
			sum_fail <= 1'b0;
		end else begin
			want <= (bus.cnt >= off_ethertype && bus.cnt < off_ip_hdr + 1) ||
				(bus.cnt >= off_ip_flags && bus.cnt < off_ip_flags + 2);
			mask_df <= bus.cnt == off_ip_flags;
			ttl_flag <= bus.cnt == off_ip_ttl;
			sum_clear <= bus.cnt == 0;
			sum_gate <= bus.cnt >= off_ip_hdr && bus.cnt < off_ip_hdr + ip_hdr_len;
			if (want && (bus.data & df_mask) != tmpl) pass_r <= 1'b0;
			// Expired packet
			if (ttl_flag && bus.data == 8'h00) pass_r <= 1'b0;
			// Header sum complete one cycle after octet 33
			if (bus.cnt == off_ip_hdr + ip_hdr_len + 1) sum_fail <= ~sum_ok;
			if (bus.cnt == 0) begin
				pass_r <= 1'b1;
				sum_fail <= 1'b0;
			end
		end
	end

	ones_chksum u_hdr_sum (
		.clk(clk),
		.rst_n(rst_n),
		.clear(sum_clear),
		.gate(sum_gate),
		.din(bus.data),
		.all_ones(sum_ok)
	);

	assign pass = pass_r & ~sum_fail;

endmodule

`default_nettype wire

//--- hw/crc32_check.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_check (
	input wire logic clk,
	input wire logic rst_n,
	scan_bus_if.chk bus,
	output logic crc_ok
);
	import rx_scan_pkg::*;

	logic [31:0] crc;

	// One octet of the LSB-first CRC-32
	function automatic logic [31:0] crc_step(logic [31:0] c, octet_t d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i]) r = (r >> 1) ^ crc_poly;
			else r = r >> 1;
		end
		return r;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crc <= crc_init;
		end else if (bus.first) begin
			// Restart on the first destination MAC octet
			crc <= crc_step(crc_init, bus.data);
		end else if (bus.gate) begin
			crc <= crc_step(crc, bus.data);
		end
	end

	// FCS included, so a good frame leaves the fixed residue
	assign crc_ok = crc == crc_residue;

endmodule

`default_nettype wire

//--- hw/ones_chksum.sv
`timescale 1ns/1ps
`default_nettype none

module ones_chksum (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic clear,
	input wire logic gate,
	input wire rx_scan_pkg::octet_t din,
	output logic all_ones
);
	import rx_scan_pkg::*;

	logic [15:0] sum;
	octet_t hi;
	logic odd;
	logic [16:0] add_full;
	logic [16:0] pend_full;
	logic [15:0] pend;

	// Completed word with end-around carry
	assign add_full = {1'b0, sum} + {1'b0, hi, din};
	// Dangling high octet padded with zero
	assign pend_full = {1'b0, sum} + {1'b0, hi, 8'h00};
	assign pend = pend_full[15:0] + 16'(pend_full[16]);
	assign all_ones = odd ? (pend == 16'hffff) : (sum == 16'hffff);

	always_ff @(posedge clk) begin
		if (gate && !odd) hi <= din;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum <= '0;
			odd <= 1'b0;
		end else if (clear) begin
			sum <= '0;
			odd <= 1'b0;
		end else if (gate) begin
			if (odd) sum <= add_full[15:0] + 16'(add_full[16]);
			odd <= ~odd;
		end
	end

endmodule

`default_nettype wire

//--- hw/frame_sync.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sync (
	input wire logic clk,
	input wire logic rst_n,
	input wire rx_scan_pkg::octet_t eth_in,
	input wire logic eth_in_s,
	input wire logic enable_rx,
	scan_bus_if.src bus,
	output rx_scan_pkg::octet_t odata,
	output logic odata_s,
	output logic odata_f,
	output rx_scan_pkg::oct_cnt_t pack_len
);
	import rx_scan_pkg::*;

	frame_state_t state;
	logic [3:0] ifg_cnt;
	logic ifg_inc;
	logic ifg_ok;
	logic in_data;
	oct_cnt_t cnt;
	logic gate_d1;
	logic first;
	octet_t data_d1;

	assign in_data = state == st_data;
	// Gap counter saturates at 12
	assign ifg_inc = ~&ifg_cnt[3:2];
	assign ifg_ok = ifg_cnt >= ifg_min;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			ifg_cnt <= '0;
		end else begin
			// Idle and preamble cycles both count toward the gap
			if (state == st_idle || state == st_preamble) ifg_cnt <= ifg_cnt + 4'(ifg_inc);
			else ifg_cnt <= '0;
			case (state)
				st_idle: begin
					if (eth_in_s) state <= (eth_in == pre_octet && enable_rx) ? st_preamble : st_drop;
				end
				st_preamble: begin
					if (!eth_in_s) state <= st_idle;
					else if (eth_in == sfd_octet) state <= ifg_ok ? st_data : st_drop;
					else if (eth_in != pre_octet) state <= st_drop;
				end
				st_data: begin
					if (!eth_in_s) state <= st_idle;
					// Oversize frame
					else if (cnt >= max_frame) state <= st_drop;
				end
				default: begin
					// Wait for the strobe to end
					if (!eth_in_s) state <= st_idle;
				end
			endcase
		end
	end

	// Octet counter and two-stage strobe pipeline
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			gate_d1 <= 1'b0;
			first <= 1'b0;
			odata_s <= 1'b0;
		end else begin
			cnt <= in_data ? cnt + 1'b1 : '0;
			gate_d1 <= in_data;
			first <= in_data & ~gate_d1;
			// st_data runs one cycle past the last octet
			odata_s <= in_data & gate_d1;
		end
	end

	always_ff @(posedge clk) begin
		data_d1 <= eth_in_s ? eth_in : '0;
		odata <= data_d1;
		// Last count seen in st_data is the frame length
		if (in_data) pack_len <= cnt;
	end

	assign odata_f = gate_d1 & ~in_data;

	assign bus.cnt = cnt;
	assign bus.data = data_d1;
	assign bus.gate = gate_d1;
	assign bus.first = first;

endmodule

`default_nettype wire

//--- hw/scan_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface scan_bus_if;
	import rx_scan_pkg::*;

	// Octet index, runs one ahead of data
	oct_cnt_t cnt;
	// Delayed octet, zero outside the strobe
	octet_t data;
	// Frame data is active
	logic gate;
	// Marks the first destination MAC octet
	logic first;

	modport src (output cnt, output data, output gate, output first);
	modport chk (input cnt, input data, input gate, input first);

endinterface

`default_nettype wire

//--- hw/rx_scan_pkg.sv
`default_nettype none

package rx_scan_pkg;

	// Widths with a protocol meaning
	typedef logic [7:0] octet_t;
	typedef logic [10:0] oct_cnt_t;
	typedef logic [15:0] len16_t;
	typedef logic [2:0] port_idx_t;

	// Frame category reported in status_vec[1:0]
	typedef logic [1:0] category_t;
	localparam category_t cat_other = 2'd0;
	localparam category_t cat_arp = 2'd1;
	localparam category_t cat_icmp = 2'd2;
	localparam category_t cat_udp = 2'd3;

	typedef enum logic [1:0] {st_idle, st_preamble, st_data, st_drop} frame_state_t;

	localparam int max_frame = 1536;
	localparam int ifg_min = 10;
	localparam int pno_entries = 8;

	// Configuration memory map
	localparam int mac_base = 0;
	localparam int ip_base = 6;

	// GMII framing octets
	localparam octet_t pre_octet = 8'h55;
	localparam octet_t sfd_octet = 8'hd5;

	// Reflected CRC-32 and its good-frame residue
	localparam logic [31:0] crc_poly = 32'hedb88320;
	localparam logic [31:0] crc_init = 32'hffffffff;
	localparam logic [31:0] crc_residue = 32'hdebb20e3;

	// Octet offsets counted from the first destination MAC octet
	localparam int off_src_mac = 6;
	localparam int off_ethertype = 12;
	localparam int off_ip_hdr = 14;
	localparam int off_ip_len = 16;
	localparam int off_ip_flags = 20;
	localparam int off_ip_ttl = 22;
	localparam int off_ip_proto = 23;
	localparam int off_ip_dst = 30;
	localparam int off_l4 = 34;
	localparam int off_udp_dport = 36;
	localparam int off_udp_len = 38;
	localparam int off_arp_tpa = 38;
	localparam int ip_hdr_len = 20;

endpackage

`default_nettype wire
